//--- Makefile
VERILATOR = verilator
TOP       = fetch_frontend_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert -Wall
PASS_MSG  = Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- fetch_buffer.sv
`include "fetch_defines.svh"

module fetch_buffer (
  input                      clock,
  input                      rst_n,
  input                      in_valid,    // Cache hit this cycle
  input        [`ADDR_W-1:0] in_pc,
  input        [`INST_W-1:0] in_inst,
  output logic               accept,
  input                      flush,       // Redirect
  input                      pop,         // Dispatch takes the head
  output logic [`INST_W-1:0] inst,
  output logic [`ADDR_W-1:0] npc,
  output logic               inst_valid
);

  localparam int PTR_W = $clog2(`FB_DEPTH);

  fetch_pkg::fetch_entry_t entries [`FB_DEPTH];
  fetch_pkg::fetch_entry_t head_entry;

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_pop;

  assign full       = (count == (PTR_W+1)'(`FB_DEPTH));
  assign inst_valid = (count != '0);
  assign accept     = in_valid && !full && !flush;
  assign do_pop     = pop && inst_valid;

  //////////////////////////////
  // Pointers and count
  //////////////////////////////
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= '0;                    // Drop everything fetched
      tail  <= '0;
      count <= '0;
    end else begin
      if (accept) tail <= tail + PTR_W'(1);
      if (do_pop) head <= head + PTR_W'(1);
      case ({accept, do_pop})
        2'b10:   count <= count + (PTR_W+1)'(1);
        2'b01:   count <= count - (PTR_W+1)'(1);
        default: count <= count;      // Push and pop together
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clock) begin
    if (accept) begin
      entries[tail].pc   <= in_pc;
      entries[tail].inst <= in_inst;
    end
  end

  //////////////////////////////
  // Head to dispatch
  //////////////////////////////
  assign head_entry = entries[head];
  assign inst       = head_entry.inst;
  assign npc        = head_entry.pc + `ADDR_W'(4);

endmodule

//--- fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////
`define ADDR_W      64          // Byte address
`define INST_W      32
`define LINE_W      64          // Cache line and memory beat

//////////////////////////////
// Instruction cache geometry
//////////////////////////////
`define IDX_W       5           // Address bits 7 to 3
`define TAG_W       8           // Address bits 15 to 8
`define CACHE_LINES 32

// Fetch buffer and memory bus
`define FB_DEPTH    8
`define MEM_TAG_W   4

// First fetch address out of reset
`define RESET_PC    64'h0

`endif

//--- fetch_frontend.sv
`include "fetch_defines.svh"

module fetch_frontend (
  input                            clock,
  input                            rst_n,
  input        [`MEM_TAG_W-1:0]    mem2proc_response,  // Tag for the current request
  input        [`LINE_W-1:0]       mem2proc_data,      // Line coming back
  input        [`MEM_TAG_W-1:0]    mem2proc_tag,       // Tag of the current reply
  input                            get_next_inst,      // Dispatch ready
  input                            redirect_en,
  input        [`ADDR_W-1:0]       redirect_pc,
  output fetch_pkg::bus_command_t  proc2mem_command,
  output logic [`ADDR_W-1:0]       proc2mem_addr,
  output logic [`INST_W-1:0]       inst,
  output logic [`ADDR_W-1:0]       npc,
  output logic                     inst_valid
);

  logic [`ADDR_W-1:0] fetch_addr;
  logic [`INST_W-1:0] cache_inst;
  logic               cache_hit;
  logic               fb_accept;
  logic               fill_en;
  logic [`ADDR_W-1:0] fill_addr;

  //////////////////////////////
  // Cache arrays and miss FSM
  //////////////////////////////
  icache_mem icache_mem_0 (
    .clock   (clock),
    .rst_n   (rst_n),
    .rd_pc   (fetch_addr),
    .rd_inst (cache_inst),
    .rd_hit  (cache_hit),
    .wr_en   (fill_en),
    .wr_addr (fill_addr),
    .wr_data (mem2proc_data)        // Memory line goes straight in
  );

  icache_ctrl icache_ctrl_0 (
    .clock             (clock),
    .rst_n             (rst_n),
    .miss_pc           (fetch_addr),
    .hit               (cache_hit),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .fill_en           (fill_en),
    .fill_addr         (fill_addr)
  );

  //////////////////////////////
  // PC and fetch buffer
  //////////////////////////////
  fetch_pc fetch_pc_0 (
    .clock       (clock),
    .rst_n       (rst_n),
    .advance     (fb_accept),       // Step only when the buffer takes it
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .pc          (fetch_addr)
  );

  fetch_buffer fetch_buffer_0 (
    .clock      (clock),
    .rst_n      (rst_n),
    .in_valid   (cache_hit),
    .in_pc      (fetch_addr),
    .in_inst    (cache_inst),
    .accept     (fb_accept),
    .flush      (redirect_en),
    .pop        (get_next_inst),
    .inst       (inst),
    .npc        (npc),
    .inst_valid (inst_valid)
  );

endmodule

//--- fetch_frontend_assert.sv
`include "fetch_defines.svh"

module fetch_frontend_assert (
  input                          clock,
  input                          rst_n,
  input                          inst_valid,
  input fetch_pkg::bus_command_t proc2mem_command,
  input        [`ADDR_W-1:0]     proc2mem_addr,
  input        [`MEM_TAG_W-1:0]  mem2proc_response
);
  timeunit 1ns;
  timeprecision 100ps;

  // Buffer stays empty under reset
  reset_empty: assert property (@(posedge clock) !rst_n |-> !inst_valid)
    else $error("inst_valid high while rst_n is low");

  // A load waits on the bus, unchanged, until the memory takes it
  load_stable: assert property (@(posedge clock) disable iff (!rst_n)
    (proc2mem_command == fetch_pkg::BUS_LOAD) && (mem2proc_response == '0)
    |=> (proc2mem_command == fetch_pkg::BUS_LOAD) && $stable(proc2mem_addr))
    else $error("load command or address changed before acceptance");

  load_aligned: assert property (@(posedge clock) disable iff (!rst_n)
    (proc2mem_command == fetch_pkg::BUS_LOAD) |-> (proc2mem_addr[2:0] == 3'b000))
    else $error("load address not 8-byte aligned");

endmodule

bind fetch_frontend fetch_frontend_assert fetch_frontend_assert_0 (
  .clock             (clock),
  .rst_n             (rst_n),
  .inst_valid        (inst_valid),
  .proc2mem_command  (proc2mem_command),
  .proc2mem_addr     (proc2mem_addr),
  .mem2proc_response (mem2proc_response)
);

//--- fetch_frontend_tb.sv
`include "fetch_defines.svh"

module fetch_frontend_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int     NUM_OPS    = 4000;
  localparam int     CLK_PERIOD = 100;
  localparam longint WATCHDOG   = longint'(NUM_OPS) * 10 * CLK_PERIOD;
  localparam int     STALL_LEN  = 20;
  localparam logic [`ADDR_W-1:0] PC_LIMIT = 64'hF000;  // Keeps fetch inside the tag range

  logic                    clock;
  logic                    rst_n;
  logic [`MEM_TAG_W-1:0]   mem2proc_response;
  logic [`LINE_W-1:0]      mem2proc_data;
  logic [`MEM_TAG_W-1:0]   mem2proc_tag;
  logic                    get_next_inst;
  logic                    redirect_en;
  logic [`ADDR_W-1:0]      redirect_pc;
  fetch_pkg::bus_command_t proc2mem_command;
  logic [`ADDR_W-1:0]      proc2mem_addr;
  logic [`INST_W-1:0]      inst;
  logic [`ADDR_W-1:0]      npc;
  logic                    inst_valid;

  //////////////////////////////
  // Reference and memory model
  //////////////////////////////
  logic [`ADDR_W-1:0]    exp_pc;
  logic                  sh_valid [`CACHE_LINES];
  logic [`TAG_W-1:0]     sh_tag   [`CACHE_LINES];
  logic                  mem_busy;             // One line in flight
  int                    mem_wait;
  logic [`ADDR_W-1:0]    mem_addr;
  logic [`MEM_TAG_W-1:0] mem_tag;
  logic [`MEM_TAG_W-1:0] next_tag;
  int                    stall_left;
  logic                  after_stall;
  logic                  after_redirect;
  logic                  flush_pending;
  int                    pops;
  int                    redirects;
  int                    loads;
  int                    checks [5];
  int                    errors [5];
  string                 test_name [5];
  int                    total_checks;
  int                    total_errors;

  fetch_frontend dut (
    .clock             (clock),
    .rst_n             (rst_n),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .get_next_inst     (get_next_inst),
    .redirect_en       (redirect_en),
    .redirect_pc       (redirect_pc),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .inst              (inst),
    .npc               (npc),
    .inst_valid        (inst_valid)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // Word address mixed with a constant and rotated by its low bits
  function automatic logic [`INST_W-1:0] image_word(input logic [`ADDR_W-1:0] addr);
    logic [31:0] w;
    logic [31:0] x;
    w = addr[33:2];
    x = w ^ 32'h6A09E667;
    return (x << w[4:0]) | (x >> (32 - w[4:0]));
  endfunction

  function automatic logic shadow_hit(input logic [`ADDR_W-1:0] addr);
    return sh_valid[addr[7:3]] && (sh_tag[addr[7:3]] == addr[15:8]);
  endfunction

  task automatic report_error(input int test, input string msg);
    errors[test]++;
    $display("[ERROR] %0d ns: %s: %s", $time, test_name[test], msg);
  endtask

  task automatic report_test(input int test);
    if (checks[test] == 0) begin
      errors[test]++;
      $display("Test %s: no checks were made, stimulus never reached it", test_name[test]);
    end
    $display("Test %s: %0d checks, %0d errors", test_name[test], checks[test], errors[test]);
  endtask

  //////////////////////////////
  // Memory side of the bus
  //////////////////////////////
  task automatic drive_memory();
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    mem2proc_data     = '0;
    if (mem_busy) begin
      if (mem_wait == 0) begin
        mem2proc_tag  = mem_tag;
        mem2proc_data = {image_word(mem_addr + 64'd4), image_word(mem_addr)};
        sh_valid[mem_addr[7:3]] = 1'b1;        // Fill lands at the coming edge
        sh_tag[mem_addr[7:3]]   = mem_addr[15:8];
        mem_busy = 1'b0;
      end else begin
        mem_wait--;
      end
    end else if (proc2mem_command == fetch_pkg::BUS_LOAD && ($urandom % 100) < 70) begin
      mem2proc_response = next_tag;
      mem_tag  = next_tag;
      next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      mem_addr = proc2mem_addr;
      mem_wait = 1 + int'($urandom % 5);       // Reply 2 to 6 cycles later
      mem_busy = 1'b1;
      loads++;
      checks[4] += 2;
      if (proc2mem_addr[2:0] !== 3'b000)
        report_error(4, $sformatf("load address %h not line aligned", proc2mem_addr));
      if (shadow_hit(proc2mem_addr))
        report_error(4, $sformatf("load for line %h that is still cached", proc2mem_addr));
    end
  endtask

  task automatic start_redirect();
    logic [15:0] target;
    if (($urandom % 4) == 0) begin
      target = 16'(($urandom % 32'hF000) & 32'hFFFC);
    end else begin                             // Near the stream so lines get reused
      target = 16'((32'(exp_pc[15:0]) + 32'hF000 - 128 + ($urandom % 64) * 4) % 32'hF000);
    end
    redirect_en = 1'b1;
    redirect_pc = {48'h0, target};
  endtask

  task automatic drive_stimulus();
    get_next_inst = 1'b0;
    redirect_en   = 1'b0;
    if (stall_left == 0 && ($urandom % 100) == 0) stall_left = STALL_LEN;
    if (stall_left > 0) begin
      stall_left--;
      if (stall_left == 0) after_stall = 1'b1;
    end else if (exp_pc >= PC_LIMIT) begin
      start_redirect();
    end else if (($urandom % 100) < 60) begin
      get_next_inst = 1'b1;
    end else if (($urandom % 100) < 2) begin
      start_redirect();
    end
  endtask

  task automatic check_outputs();
    int test;
    if (flush_pending) begin
      flush_pending = 1'b0;
      checks[3]++;
      if (inst_valid !== 1'b0) report_error(3, "buffer not empty in the cycle after a redirect");
    end
    if (get_next_inst && inst_valid) begin
      test = after_redirect ? 3 : (after_stall ? 2 : 1);
      checks[test] += 2;
      if (inst !== image_word(exp_pc))
        report_error(test, $sformatf("pc %h: inst %h, expected %h",
                                     exp_pc, inst, image_word(exp_pc)));
      if (npc !== exp_pc + 64'd4)
        report_error(test, $sformatf("pc %h: npc %h, expected %h", exp_pc, npc, exp_pc + 64'd4));
      exp_pc         = exp_pc + 64'd4;
      after_redirect = 1'b0;
      after_stall    = 1'b0;
      pops++;
    end
    if (redirect_en) begin
      exp_pc         = redirect_pc;
      after_redirect = 1'b1;
      flush_pending  = 1'b1;
      redirects++;
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    clock = 1'b0;
    rst_n = 1'b0;
    mem2proc_response = '0;
    mem2proc_data     = '0;
    mem2proc_tag      = '0;
    get_next_inst     = 1'b0;
    redirect_en       = 1'b0;
    redirect_pc       = '0;
    exp_pc   = `RESET_PC;
    mem_busy = 1'b0;
    mem_wait = 0;
    mem_addr = '0;
    mem_tag  = '0;
    next_tag = 4'd1;
    stall_left = 0;
    after_stall    = 1'b0;
    after_redirect = 1'b0;
    flush_pending  = 1'b0;
    pops = 0;
    redirects = 0;
    loads = 0;
    for (int i = 0; i < `CACHE_LINES; i++) begin
      sh_valid[i] = 1'b0;
      sh_tag[i]   = '0;
    end
    for (int i = 0; i < 5; i++) begin
      checks[i] = 0;
      errors[i] = 0;
    end
    test_name[0] = "reset";
    test_name[1] = "stream";
    test_name[2] = "back-pressure";
    test_name[3] = "redirect";
    test_name[4] = "cache requests";
    void'($urandom(32'h327136ad));

    repeat (3) begin
      @(posedge clock);
      checks[0] += 2;
      if (inst_valid !== 1'b0) report_error(0, "inst_valid high during reset");
      if (proc2mem_command !== fetch_pkg::BUS_NONE) report_error(0, "bus command during reset");
    end
    #5 rst_n = 1'b1;
    @(negedge clock);
    checks[0] += 2;
    if (inst_valid !== 1'b0) report_error(0, "inst_valid high right after reset");
    if (proc2mem_command !== fetch_pkg::BUS_NONE) report_error(0, "bus command right after reset");
    while (proc2mem_command != fetch_pkg::BUS_LOAD) @(negedge clock);
    checks[0]++;
    if (proc2mem_addr !== (`RESET_PC & ~64'h7))
      report_error(0, $sformatf("first load at %h, not the reset line", proc2mem_addr));
    report_test(0);

    repeat (NUM_OPS) begin
      @(posedge clock);
      #5;
      drive_memory();
      drive_stimulus();
      @(negedge clock);
      check_outputs();
    end

    for (int i = 1; i < 5; i++) report_test(i);
    total_checks = 0;
    total_errors = 0;
    for (int i = 0; i < 5; i++) begin
      total_checks += checks[i];
      total_errors += errors[i];
    end
    $display("Totals: %0d checks, %0d errors, %0d pops, %0d redirects, %0d loads",
             total_checks, total_errors, pops, redirects, loads);
    if (total_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG);
    $display("Watchdog timeout: the run did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule

//--- fetch_pc.sv
`include "fetch_defines.svh"

module fetch_pc (
  input                      clock,
  input                      rst_n,
  input                      advance,       // Instruction taken by the buffer
  input                      redirect_en,
  input        [`ADDR_W-1:0] redirect_pc,
  output logic [`ADDR_W-1:0] pc
);

  fetch_pkg::addr_t pc_q;
  fetch_pkg::addr_t pc_next;

  //////////////////////////////
  // Next PC select
  //////////////////////////////
  always_comb begin
    pc_next = pc_q;
    if (redirect_en) begin
      pc_next = redirect_pc;           // Redirect wins
    end else if (advance) begin
      pc_next = pc_q + `ADDR_W'(4);
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // Held PC under back-pressure
  assign pc = pc_q;

endmodule

//--- fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

  // Memory bus commands
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_t;

  // Miss handling states
  typedef enum logic [1:0] {
    IDLE      = 2'h0,
    REQUEST   = 2'h1,           // Load on the bus until accepted
    WAIT_DATA = 2'h2            // Waiting for our tag to come back
  } icache_state_t;

  //////////////////////////////
  // Address pieces
  //////////////////////////////
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`IDX_W-1:0]  cache_idx_t;
  typedef logic [`TAG_W-1:0]  cache_tag_t;

  // One slot of the fetch buffer
  typedef struct packed {
    logic [`ADDR_W-1:0] pc;
    logic [`INST_W-1:0] inst;
  } fetch_entry_t;

endpackage

//--- icache_ctrl.sv
`include "fetch_defines.svh"

module icache_ctrl (
  input                                clock,
  input                                rst_n,
  input        [`ADDR_W-1:0]           miss_pc,            // Current fetch PC
  input                                hit,
  input        [`MEM_TAG_W-1:0]        mem2proc_response,  // Nonzero accepts the load
  input        [`MEM_TAG_W-1:0]        mem2proc_tag,       // Tag of the returning line
  output fetch_pkg::bus_command_t      proc2mem_command,
  output logic [`ADDR_W-1:0]           proc2mem_addr,
  output logic                         fill_en,
  output logic [`ADDR_W-1:0]           fill_addr
);

  fetch_pkg::icache_state_t state;
  fetch_pkg::icache_state_t state_next;

  fetch_pkg::addr_t      line_addr;    // Line being fetched
  logic [`MEM_TAG_W-1:0] pending_tag;  // Tag the memory gave us
  logic                  req_taken;
  logic                  data_back;

  assign req_taken = (state == fetch_pkg::REQUEST) && (mem2proc_response != '0);
  assign data_back = (state == fetch_pkg::WAIT_DATA) && (mem2proc_tag == pending_tag);

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      fetch_pkg::IDLE: begin
        if (!hit) begin
          state_next = fetch_pkg::REQUEST;
        end
      end
      fetch_pkg::REQUEST: begin
        if (req_taken) begin
          state_next = fetch_pkg::WAIT_DATA;
        end
      end
      fetch_pkg::WAIT_DATA: begin
        if (data_back) begin
          state_next = fetch_pkg::IDLE;
        end
      end
      default: state_next = fetch_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= fetch_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Miss address and memory tag
  always_ff @(posedge clock) begin
    if ((state == fetch_pkg::IDLE) && !hit) begin
      line_addr <= {miss_pc[`ADDR_W-1:3], 3'b000};  // Align to 8 bytes
    end
    if (req_taken) begin
      pending_tag <= mem2proc_response;
    end
  end

  //////////////////////////////
  // Bus and fill outputs
  //////////////////////////////
  always_comb begin
    proc2mem_command = fetch_pkg::BUS_NONE;
    proc2mem_addr    = '0;
    if (state == fetch_pkg::REQUEST) begin
      proc2mem_command = fetch_pkg::BUS_LOAD;
      proc2mem_addr    = line_addr;
    end
  end

  assign fill_en   = data_back;
  assign fill_addr = line_addr;       // Held since the miss

endmodule

//--- icache_mem.sv
`include "fetch_defines.svh"

module icache_mem (
  input                      clock,
  input                      rst_n,
  input        [`ADDR_W-1:0] rd_pc,     // Fetch address
  output logic [`INST_W-1:0] rd_inst,
  output logic               rd_hit,
  input                      wr_en,     // Line fill
  input        [`ADDR_W-1:0] wr_addr,
  input        [`LINE_W-1:0] wr_data
);

  fetch_pkg::cache_idx_t rd_idx;
  fetch_pkg::cache_tag_t rd_tag;
  fetch_pkg::cache_idx_t wr_idx;
  fetch_pkg::cache_tag_t wr_tag;

  logic [`CACHE_LINES-1:0] valid;
  fetch_pkg::cache_tag_t   tags  [`CACHE_LINES];
  logic [`LINE_W-1:0]      lines [`CACHE_LINES];

  // Bits 2..0 are the byte offset within a line
  assign rd_idx = rd_pc[`IDX_W+2:3];
  assign rd_tag = rd_pc[`TAG_W+`IDX_W+2:`IDX_W+3];
  assign wr_idx = wr_addr[`IDX_W+2:3];
  assign wr_tag = wr_addr[`TAG_W+`IDX_W+2:`IDX_W+3];

  //////////////////////////////
  // Read port
  //////////////////////////////
  assign rd_hit  = valid[rd_idx] && (tags[rd_idx] == rd_tag);
  assign rd_inst = rd_pc[2] ? lines[rd_idx][`LINE_W-1:`INST_W]   // Upper word
                            : lines[rd_idx][`INST_W-1:0];

  //////////////////////////////
  // Fill port
  //////////////////////////////
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      tags[wr_idx]  <= wr_tag;
      lines[wr_idx] <= wr_data;
    end
  end

endmodule

//--- project.f
+incdir+.
fetch_pkg.sv
icache_mem.sv
icache_ctrl.sv
fetch_pc.sv
fetch_buffer.sv
fetch_frontend.sv
fetch_frontend_assert.sv
fetch_frontend_tb.sv
